/* hw/chanlink_pkg.sv */
package chanlink_pkg;

	typedef struct packed {
		logic        evt_end; // Last sample of the event
		logic        movlp;   // Multiple overlap
		logic        ovrlp;
		logic [11:0] data;    // ADC word
	} smp_word_t;

	typedef struct packed {
		logic        phase;
		logic [23:0] l1a_cnt;
	} l1a_rec_t;

	// Frame layout
	localparam int EVT_WORDS   = 96;
	localparam int FRAME_WORDS = EVT_WORDS + 4;
	localparam logic [15:0] MARK_HDR = 16'h700C;
	localparam logic [15:0] MARK_END = 16'h7FFF;

	localparam int SER_PHASE_FIRST = 72; // Serial bit carries L1A phase
	localparam int SER_PHASE_LAST  = 77;
	localparam int SER_MODE_FIRST  = 90; // Serial bit flags 16 sample mode
	localparam int SER_MODE_LAST   = 95;
	localparam logic [6:0] SAMP16  = 7'h0F;

	// CRC-15, 13 data bits per step
	function automatic logic [14:0] crc15_d13(input logic [12:0] d, input logic [14:0] c);
		logic [14:0] n;
		n[0]  = d[0] ^ c[2];
		for (int i = 1; i <= 12; i++) begin
			n[i] = d[i-1] ^ d[i] ^ c[i+1] ^ c[i+2];
		end
		n[13] = d[12] ^ c[14] ^ c[0];
		n[14] = c[1];
		return n;
	endfunction

endpackage

/* hw/chanlink_buf.sv */
`timescale 1ns/1ns

module chanlink_buf #(
	parameter type T = logic [7:0],
	parameter int DEPTH_LOG2 = 4
) (
	input  logic                RCLK,
	input  logic                RST_RESYNC,
	input  logic                wr,
	input  T                    din,
	input  logic                rd,
	output T                    dout,
	output logic                empty,
	output logic                full,
	output logic [DEPTH_LOG2:0] count
);

	localparam int DEPTH = 1 << DEPTH_LOG2;

	T mem [DEPTH];

	logic [DEPTH_LOG2-1:0] wr_ptr;
	logic [DEPTH_LOG2-1:0] rd_ptr;
	logic                  do_wr;
	logic                  do_rd;

	assign do_wr = wr && !full;  // Dropped when full
	assign do_rd = rd && !empty;

	assign empty = (count == '0);
	assign full  = count[DEPTH_LOG2]; // Count never exceeds DEPTH

	//////////////////////////////////////////////////
	// Storage and registered read port
	//////////////////////////////////////////////////
	always_ff @(posedge RCLK) begin
		if (do_wr)
			mem[wr_ptr] <= din;
		if (do_rd)
			dout <= mem[rd_ptr];
	end

	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1; // Wraps at DEPTH
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_wr && !do_rd)
				count <= count + 1'b1;
			else if (do_rd && !do_wr)
				count <= count - 1'b1;
		end
	end

	// Overflow loses data upstream
	a_no_wr_full: assert property (@(posedge RCLK) disable iff (RST_RESYNC)
		wr |-> !full)
		else $error("chanlink_buf: write while full, word dropped");

	a_no_rd_empty: assert property (@(posedge RCLK) disable iff (RST_RESYNC)
		rd |-> !empty)
		else $error("chanlink_buf: read while empty");

endmodule

/* hw/frame_seq_fsm.sv */
`timescale 1ns/1ns

module frame_seq_fsm (
	input  logic       RCLK,
	input  logic       RST_RESYNC,
	input  logic       evt_ready,
	input  logic       l1a_empty,
	output logic       smp_rd,
	output logic       l1a_rd,
	output logic       clr_crc,
	output logic       evt_done,
	output logic       valid,
	output logic       last,
	output logic [6:0] seq
);

	localparam logic [6:0] SMP_LAST = 7'(chanlink_pkg::EVT_WORDS - 1);
	localparam logic [6:0] FRM_LAST = 7'(chanlink_pkg::FRAME_WORDS - 1);

	typedef enum logic [1:0] {
		IDLE,
		LOAD,   // Pop L1A record, clear CRC
		STREAM, // One sample read per cycle
		TRAIL   // CRC, markers and trigger word
	} state_t;

	state_t state;
	state_t state_nxt;

	//////////////////////////////////////////////////
	// Next state
	//////////////////////////////////////////////////
	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (evt_ready && !l1a_empty)
					state_nxt = LOAD;
			end
			LOAD:
				state_nxt = STREAM;
			STREAM: begin
				if (seq == SMP_LAST)
					state_nxt = TRAIL;
			end
			TRAIL: begin
				if (seq == FRM_LAST)
					state_nxt = IDLE; // Forces an idle gap
			end
			default:
				state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			state <= IDLE;
			seq   <= 7'd0;
		end else begin
			state <= state_nxt;
			// Counts words while the frame stays open
			if ((state == STREAM || state == TRAIL) && state_nxt != IDLE)
				seq <= seq + 7'd1;
			else
				seq <= 7'd0;
		end
	end

	// Strobes, decoded from state and word count
	assign l1a_rd   = (state == LOAD);
	assign clr_crc  = (state == LOAD);
	assign smp_rd   = (state == STREAM);
	assign valid    = (state == STREAM) || (state == TRAIL);
	assign last     = (state == TRAIL) && (seq == FRM_LAST);
	assign evt_done = (state == STREAM) && (seq == SMP_LAST); // Samples all taken

	a_seq_range: assert property (@(posedge RCLK) disable iff (RST_RESYNC)
		seq <= FRM_LAST)
		else $error("frame_seq_fsm: word counter past end of frame");

endmodule

/* hw/chanlink_framer.sv */
`timescale 1ns/1ns

module chanlink_framer #(
	parameter int L1A_DEPTH_LOG2 = 4
) (
	input  logic                     RCLK,
	input  logic                     RST_RESYNC,
	input  logic                     evt_ready,
	input  chanlink_pkg::smp_word_t  smp_q,
	input  chanlink_pkg::l1a_rec_t   l1a_q,
	input  logic [L1A_DEPTH_LOG2:0]  l1a_count,
	input  logic                     l1a_empty,
	input  logic [6:0]               samp_max,
	input  logic                     warn,
	output logic                     smp_rd,
	output logic                     l1a_rd,
	output logic                     evt_done,
	output logic [15:0]              dout,
	output logic                     dvalid,
	output logic                     last_wrd,
	output logic                     mlt_ovlp
);

	logic        clr_crc;
	logic        valid;
	logic        last;
	logic [6:0]  seq;
	logic        valid_d;  // Aligned with buffer data
	logic        last_d;
	logic        l1a_rd_d;
	logic [6:0]  seq_d;
	logic        is_smp;
	logic        serial;
	logic [14:0] crc;
	logic [4:0]  l1a_depth;
	logic [15:0] word;

	frame_seq_fsm seq_i (
		.RCLK       (RCLK),
		.RST_RESYNC (RST_RESYNC),
		.evt_ready  (evt_ready),
		.l1a_empty  (l1a_empty),
		.smp_rd     (smp_rd),
		.l1a_rd     (l1a_rd),
		.clr_crc    (clr_crc),
		.evt_done   (evt_done),
		.valid      (valid),
		.last       (last),
		.seq        (seq)
	);

	assign is_smp = valid_d && (seq_d < 7'(chanlink_pkg::EVT_WORDS));

	//////////////////////////////////////////////////
	// Word formatting
	//////////////////////////////////////////////////
	always_comb begin
		serial = 1'b0;
		if (seq_d >= 7'(chanlink_pkg::SER_PHASE_FIRST) &&
		    seq_d <= 7'(chanlink_pkg::SER_PHASE_LAST))
			serial = l1a_q.phase;
		else if (seq_d >= 7'(chanlink_pkg::SER_MODE_FIRST) &&
		         seq_d <= 7'(chanlink_pkg::SER_MODE_LAST))
			serial = (samp_max == chanlink_pkg::SAMP16);
	end

	always_comb begin
		case (seq_d)
			7'(chanlink_pkg::EVT_WORDS):     word = {1'b0, crc};
			7'(chanlink_pkg::EVT_WORDS + 1): word = chanlink_pkg::MARK_HDR;
			7'(chanlink_pkg::EVT_WORDS + 2): word = {4'h7, l1a_q.l1a_cnt[5:0], l1a_depth, warn};
			7'(chanlink_pkg::EVT_WORDS + 3): word = chanlink_pkg::MARK_END;
			default: word = {1'b0, ~smp_q.ovrlp, serial, 1'b0, smp_q.data};
		endcase
	end

	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			crc <= 15'd0;
		end else if (clr_crc) begin
			crc <= 15'd0;
		end else if (is_smp) begin
			crc <= chanlink_pkg::crc15_d13({1'b0, smp_q.data}, crc);
		end
	end

	always_ff @(posedge RCLK) begin
		seq_d <= seq;
		if (l1a_rd_d) // Count already shows the record gone
			l1a_depth <= (l1a_count > 31) ? 5'd31 : 5'(l1a_count);
	end

	//////////////////////////////////////////////////
	// Output registers
	//////////////////////////////////////////////////
	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			valid_d  <= 1'b0;
			last_d   <= 1'b0;
			l1a_rd_d <= 1'b0;
			dvalid   <= 1'b0;
			last_wrd <= 1'b0;
			mlt_ovlp <= 1'b0;
			dout     <= 16'h0000;
		end else begin
			valid_d  <= valid;
			last_d   <= last;
			l1a_rd_d <= l1a_rd;
			dvalid   <= valid_d;
			last_wrd <= last_d;
			mlt_ovlp <= is_smp && smp_q.movlp;
			dout     <= valid_d ? word : 16'h0000;
		end
	end

	// Sample count and buffer event boundary must agree
	a_evt_end: assert property (@(posedge RCLK) disable iff (RST_RESYNC)
		(valid_d && seq_d == 7'(chanlink_pkg::EVT_WORDS - 1)) |-> smp_q.evt_end)
		else $error("chanlink_framer: event boundary out of step with frame");

endmodule

/* hw/chanlink_top.sv */
`timescale 1ns/1ns

module chanlink_top #(
	parameter int SMP_DEPTH_LOG2 = 8,
	parameter int L1A_DEPTH_LOG2 = 4
) (
	input  logic                    RCLK,
	input  logic                    RST_RESYNC,
	input  logic                    smp_wr,
	input  chanlink_pkg::smp_word_t smp_data,
	input  logic                    l1a_wr,
	input  chanlink_pkg::l1a_rec_t  l1a_data,
	input  logic [6:0]              samp_max,
	input  logic                    warn,
	output logic [15:0]             dout,
	output logic                    dvalid,
	output logic                    last_wrd,
	output logic                    mlt_ovlp
);

	chanlink_pkg::smp_word_t smp_q;
	chanlink_pkg::l1a_rec_t  l1a_q;
	logic                    smp_rd;
	logic                    smp_full;
	logic                    l1a_rd;
	logic                    l1a_empty;
	logic [L1A_DEPTH_LOG2:0] l1a_count;
	logic                    evt_done;
	logic                    evt_in;
	logic [SMP_DEPTH_LOG2:0] evt_cnt; // Complete events held

	chanlink_buf #(.T(chanlink_pkg::smp_word_t), .DEPTH_LOG2(SMP_DEPTH_LOG2)) smp_buf_i (
		.RCLK (RCLK), .RST_RESYNC (RST_RESYNC),
		.wr (smp_wr), .din (smp_data), .rd (smp_rd), .dout (smp_q),
		.empty (), .full (smp_full), .count ()
	);

	chanlink_buf #(.T(chanlink_pkg::l1a_rec_t), .DEPTH_LOG2(L1A_DEPTH_LOG2)) l1a_buf_i (
		.RCLK (RCLK), .RST_RESYNC (RST_RESYNC),
		.wr (l1a_wr), .din (l1a_data), .rd (l1a_rd), .dout (l1a_q),
		.empty (l1a_empty), .full (), .count (l1a_count)
	);

	assign evt_in = smp_wr && !smp_full && smp_data.evt_end; // Last sample accepted

	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC)
			evt_cnt <= '0;
		else if (evt_in && !evt_done)
			evt_cnt <= evt_cnt + 1'b1;
		else if (evt_done && !evt_in)
			evt_cnt <= evt_cnt - 1'b1;
	end

	chanlink_framer #(.L1A_DEPTH_LOG2(L1A_DEPTH_LOG2)) framer_i (
		.RCLK (RCLK), .RST_RESYNC (RST_RESYNC),
		.evt_ready (evt_cnt != '0),
		.smp_q (smp_q), .l1a_q (l1a_q), .l1a_count (l1a_count), .l1a_empty (l1a_empty),
		.samp_max (samp_max), .warn (warn),
		.smp_rd (smp_rd), .l1a_rd (l1a_rd), .evt_done (evt_done),
		.dout (dout), .dvalid (dvalid), .last_wrd (last_wrd), .mlt_ovlp (mlt_ovlp)
	);

endmodule

/* verif/chanlink_tb.sv */
`timescale 1ns/1ns

module chanlink_tb;

	localparam int N_EVT = 6;
	localparam int EW    = chanlink_pkg::EVT_WORDS;
	localparam int FW    = chanlink_pkg::FRAME_WORDS;
	localparam int LIMIT = N_EVT * (FW + EW + 20) + 200; // Cycles before the run is stopped

	typedef struct packed {
		logic        phase;
		logic [23:0] l1a_cnt;
		logic [6:0]  samp_max;
		logic        warn;
		logic [31:0] seed;
	} evt_row_t;

	// Rows with equal samp_max and warn go out back to back
	evt_row_t evt_tab [N_EVT] = '{
		'{1'b1, 24'h000041, 7'h0F, 1'b0, 32'h5a17_0c03},
		'{1'b0, 24'h0000a2, 7'h0F, 1'b0, 32'h0000_0fff},
		'{1'b1, 24'h12345f, 7'h0F, 1'b0, 32'h9e37_79b9},
		'{1'b0, 24'h7fff80, 7'h08, 1'b1, 32'h0000_0000},
		'{1'b1, 24'h00003c, 7'h08, 1'b1, 32'hc0de_0a5a},
		'{1'b1, 24'hfedcb7, 7'h0F, 1'b1, 32'h1234_8765}
	};

	logic                    RCLK;
	logic                    RST_RESYNC;
	logic                    smp_wr;
	chanlink_pkg::smp_word_t smp_data;
	logic                    l1a_wr;
	chanlink_pkg::l1a_rec_t  l1a_data;
	logic [6:0]              samp_max;
	logic                    warn;
	logic [15:0]             dout;
	logic                    dvalid;
	logic                    last_wrd;
	logic                    mlt_ovlp;

	chanlink_pkg::smp_word_t smp_tab [N_EVT][EW];
	logic [15:0]             exp_word [N_EVT][FW];
	logic                    exp_mlt [N_EVT][FW];

	int err_cnt    = 0;
	int pass_cnt   = 0;
	int fail_cnt   = 0;
	int frame_idx  = 0; // Frames seen by the monitor
	int word_idx   = 0;
	int frame_err0 = 0;
	int cycles     = 0;

	chanlink_top #(.SMP_DEPTH_LOG2(8), .L1A_DEPTH_LOG2(4)) dut_i (
		.RCLK       (RCLK),
		.RST_RESYNC (RST_RESYNC),
		.smp_wr     (smp_wr),
		.smp_data   (smp_data),
		.l1a_wr     (l1a_wr),
		.l1a_data   (l1a_data),
		.samp_max   (samp_max),
		.warn       (warn),
		.dout       (dout),
		.dvalid     (dvalid),
		.last_wrd   (last_wrd),
		.mlt_ovlp   (mlt_ovlp)
	);

	always #5 RCLK = ~RCLK;

	task automatic compare_val(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			err_cnt++;
			$display("error at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
		end
	endtask

	//////////////////////////////////////////////////
	// Sample data and expected frames
	//////////////////////////////////////////////////
	task automatic build_events();
		logic [14:0] crc;
		logic        serial;
		for (int e = 0; e < N_EVT; e++) begin
			crc = 15'd0; // Fresh CRC per event
			for (int w = 0; w < EW; w++) begin
				smp_tab[e][w].data    = 12'($urandom ^ evt_tab[e].seed);
				smp_tab[e][w].ovrlp   = ((w + e) % 11 == 0);
				smp_tab[e][w].movlp   = ((w + 3 * e) % 17 == 5);
				smp_tab[e][w].evt_end = (w == EW - 1);
				if (w >= chanlink_pkg::SER_PHASE_FIRST && w <= chanlink_pkg::SER_PHASE_LAST)
					serial = evt_tab[e].phase;
				else if (w >= chanlink_pkg::SER_MODE_FIRST && w <= chanlink_pkg::SER_MODE_LAST)
					serial = (evt_tab[e].samp_max == chanlink_pkg::SAMP16);
				else
					serial = 1'b0;
				exp_word[e][w] = {1'b0, ~smp_tab[e][w].ovrlp, serial, 1'b0, smp_tab[e][w].data};
				exp_mlt[e][w]  = smp_tab[e][w].movlp;
				crc = chanlink_pkg::crc15_d13({1'b0, smp_tab[e][w].data}, crc);
			end
			exp_word[e][EW]     = {1'b0, crc};
			exp_word[e][EW + 1] = chanlink_pkg::MARK_HDR;
			// Records left behind this one, all loaded up front
			exp_word[e][EW + 2] = {4'h7, evt_tab[e].l1a_cnt[5:0], 5'(N_EVT - e - 1),
			                       evt_tab[e].warn};
			exp_word[e][EW + 3] = chanlink_pkg::MARK_END;
			for (int w = EW; w < FW; w++)
				exp_mlt[e][w] = 1'b0;
		end
	endtask

	task automatic load_triggers();
		for (int e = 0; e < N_EVT; e++) begin
			@(posedge RCLK);
			#1;
			l1a_wr   = 1'b1;
			l1a_data = {evt_tab[e].phase, evt_tab[e].l1a_cnt};
		end
		@(posedge RCLK);
		#1;
		l1a_wr = 1'b0;
	endtask

	task automatic send_event(input int e);
		for (int w = 0; w < EW; w++) begin
			@(posedge RCLK);
			#1;
			smp_wr   = 1'b1;
			smp_data = smp_tab[e][w];
		end
		@(posedge RCLK);
		#1;
		smp_wr = 1'b0;
	endtask

	//////////////////////////////////////////////////
	// Frame monitor
	//////////////////////////////////////////////////
	always @(negedge RCLK) begin
		if (dvalid) begin
			if (word_idx == 0)
				frame_err0 = err_cnt;
			if (frame_idx >= N_EVT) begin
				if (word_idx == 0) begin
					err_cnt++;
					$display("unexpected frame after the last table event at %0t ns", $time);
				end
			end else if (word_idx < FW) begin
				compare_val(32'(dout), 32'(exp_word[frame_idx][word_idx]),
				            $sformatf("event %0d word %0d dout", frame_idx, word_idx));
				compare_val(32'(mlt_ovlp), 32'(exp_mlt[frame_idx][word_idx]),
				            $sformatf("event %0d word %0d mlt_ovlp", frame_idx, word_idx));
				compare_val(32'(last_wrd), 32'(word_idx == FW - 1),
				            $sformatf("event %0d word %0d last_wrd", frame_idx, word_idx));
			end else if (word_idx == FW) begin
				err_cnt++;
				$display("event %0d: dvalid still high after %0d words", frame_idx, FW);
			end
			word_idx++;
		end else begin
			compare_val(32'(last_wrd), 32'd0, "last_wrd outside a frame");
			compare_val(32'(mlt_ovlp), 32'd0, "mlt_ovlp outside a frame");
			if (word_idx != 0) begin // Frame just ended
				if (frame_idx < N_EVT) begin
					compare_val(32'(word_idx), 32'(FW), $sformatf("event %0d frame length", frame_idx));
					if (err_cnt == frame_err0) begin
						pass_cnt++;
						$display("event %0d (l1a %06h): pass", frame_idx, evt_tab[frame_idx].l1a_cnt);
					end else begin
						fail_cnt++;
						$display("event %0d (l1a %06h): fail", frame_idx, evt_tab[frame_idx].l1a_cnt);
					end
				end
				frame_idx++;
				word_idx = 0;
			end
		end
	end

	always @(posedge RCLK) begin
		cycles++;
		if (cycles >= LIMIT) begin
			$display("timeout: %0d of %0d frames received after %0d cycles",
			         frame_idx, N_EVT, cycles);
			$display("Result: FAILED");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////
	initial begin
		int err0;
		RCLK       = 1'b0;
		RST_RESYNC = 1'b1;
		smp_wr     = 1'b0;
		smp_data   = '0;
		l1a_wr     = 1'b0;
		l1a_data   = '0;
		samp_max   = evt_tab[0].samp_max;
		warn       = evt_tab[0].warn;
		void'($urandom(32'h41e4));
		build_events();

		err0 = err_cnt;
		repeat (5) begin
			@(negedge RCLK);
			compare_val(32'({dvalid, last_wrd, mlt_ovlp, dout}), 32'd0, "outputs during reset");
		end
		@(posedge RCLK);
		#1;
		RST_RESYNC = 1'b0;
		@(negedge RCLK);
		compare_val(32'({dvalid, last_wrd, mlt_ovlp, dout}), 32'd0, "outputs after reset");
		if (err_cnt == err0) begin
			pass_cnt++;
			$display("reset: pass");
		end else begin
			fail_cnt++;
			$display("reset: fail");
		end

		load_triggers();
		for (int e = 0; e < N_EVT; e++) begin
			// Levels change only once earlier frames are out
			if (samp_max != evt_tab[e].samp_max || warn != evt_tab[e].warn) begin
				while (frame_idx < e)
					@(posedge RCLK);
				@(posedge RCLK);
				#1;
				samp_max = evt_tab[e].samp_max;
				warn     = evt_tab[e].warn;
			end
			send_event(e);
		end

		wait (frame_idx >= N_EVT);
		repeat (20) @(posedge RCLK); // Catch any stray frame
		$display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
		if (err_cnt == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

/* sources.f */
hw/chanlink_pkg.sv
hw/chanlink_buf.sv
hw/frame_seq_fsm.sv
hw/chanlink_framer.sv
hw/chanlink_top.sv
verif/chanlink_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ns
TOP       = chanlink_tb
FILELIST  = sources.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SRCS      = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Result: PASSED" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
